// File: tb/px_golden.txt
# kind op addr data expected, values in hex; kind C is the CPU, H the channel
# C ops: L load, S store, A/X load/store to an absent module, R reset; H ops: R, W, B hold
C S 0010 1234 0000
C L 0010 0000 1234
C S 1ffe beef 0000
C L 1ffe 0000 beef
H W 0200 a5a5 0000
C L 0200 0000 a5a5
C S 0300 5a5a 0000
H R 0300 0000 5a5a
H B 0400 c3c3 c3c3
C S 1010 6e6e 0000
C X 3010 dead 0000
H R 1010 0000 6e6e
H R 0200 0000 a5a5
C R 0000 0000 0000
C L 1010 0000 6e6e
C A f123 0000 0000
C R 0000 0000 0000
H W 0010 0f0f 0000
C L 0010 0000 0f0f
C S 0020 7777 0000
H R 0020 0000 7777

// File: files.f
hdl/px_pkg.sv
hdl/strobgen.sv
hdl/ifctl.sv
hdl/px.sv
hdl/bus_arbiter.sv
hdl/mem_slave.sv
hdl/px_top.sv
tb/px_tb.sv

// File: Makefile
# Verilator build and run of the px testbench

all:
	verilator --binary --timing -j 0 --top-module px_tb -f files.f -o px_sim
	@out=$$(./obj_dir/px_sim); echo "$$out"; echo "$$out" | grep -qx "Done: no errors"

lint:
	verilator --lint-only -Wall --timing --top-module px_tb -f files.f

clean:
	rm -rf obj_dir

.PHONY: all lint clean

// File: tb/px_tb.sv
`timescale 1ns/10ps

module px_tb;

	import px_pkg::*;

	localparam int ALARM_TICKS = 16;	// No-reply timeout of the DUT
	localparam int LIMIT = 200;	// Clocks allowed for any wait

	logic __clk, clo, start;
	op_t op;
	addr_t arg, ch_dad;
	word_t wdata, rdata, ch_ddt, ch_dt;
	logic done, hlt_n, awaria;
	logic ch_zg, ch_dr, ch_dw, ch_zw, ch_rok, ch_ren;	// Channel master pins

	px_top #(.ALARM_TICKS(ALARM_TICKS), .STOP_ON_NOMEM(1'b1), .MEM_MODULES(2)) i_dut(.*);

	initial begin
		__clk = 1'b0;
		forever #4 __clk = ~__clk;	// 8 ns period
	end

	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("Done: errors found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			stop_with_error($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp)
			stop_with_error($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_with_error($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	// One clock of a bounded wait
	task automatic step(inout int n, input int limit, input string what);
		@(negedge __clk);
		n++;
		if (n > limit) stop_with_error($sformatf("Timeout waiting for %s", what));
	endtask

	task automatic apply_reset();
		@(posedge __clk);
		clo <= 1'b1;
		repeat (4) @(posedge __clk);
		clo <= 1'b0;
		@(negedge __clk);
		check_bit("done", done, 1'b0);	// Levels right after clear
		check_bit("awaria", awaria, 1'b0);
		check_bit("hlt_n", hlt_n, 1'b1);
	endtask

	// CPU operation where absent marks a missing operand module
	task automatic run_cpu(input op_t o, input addr_t a, input word_t d, input bit absent,
		output word_t rd);
		int n;
		int limit;
		limit = absent ? ALARM_TICKS + 24 : LIMIT;	// Alarm must come in time
		@(posedge __clk);
		start <= 1'b1;
		op <= o;
		arg <= a;
		wdata <= d;
		@(posedge __clk);
		start <= 1'b0;	// Single clock start pulse
		n = 0;
		do begin
			step(n, limit, "end of CPU operation");
			if ((i_dut.cpu_dr | i_dut.cpu_dw) & ~i_dut.u_px.k1)
				check_addr("cpu_dad", i_dut.cpu_dad, a);	// Operand address on the bus
			if (absent) check_bit("done", done, 1'b0);
		end while (absent ? !awaria : !done);
		rd = rdata;
		if (absent) check_bit("hlt_n", hlt_n, 1'b0);
		repeat (absent ? 8 : 1) begin
			@(negedge __clk);
			check_bit("done", done, 1'b0);	// Single pulse and none after a fault
		end
	endtask

	// Channel access that holds the bus for hold clocks before the strobe
	task automatic chan_access(input bit write, input addr_t a, input word_t d, input int hold,
		output word_t rd);
		int n;
		@(posedge __clk);
		ch_zg <= 1'b1;
		n = 0;
		do step(n, LIMIT, "ch_zw"); while (!ch_zw);
		repeat (hold) @(posedge __clk);
		@(posedge __clk);
		ch_dr <= ~write;
		ch_dw <= write;
		ch_dad <= a;
		ch_ddt <= d;
		n = 0;
		do begin
			step(n, LIMIT, "ch_rok");
			check_bit("ch_ren", ch_ren, 1'b0);	// Memory never answers with EN
		end while (!ch_rok);
		rd = ch_dt;	// Read data comes with OK
		@(posedge __clk);
		ch_zg <= 1'b0;
		ch_dr <= 1'b0;
		ch_dw <= 1'b0;
	endtask

	// Channel grant and CPU strobes must never meet
	always @(negedge __clk) begin
		if (!clo)
			check_bit("ch_zw & cpu strobe", ch_zw & (i_dut.cpu_dr | i_dut.cpu_dw), 1'b0);
	end

	initial begin
		int fd, n;
		string line;
		logic [7:0] kind, opc;
		addr_t a;
		word_t d, e, rd, cd;
		void'($urandom(32'h50af_d7ec));
		clo = 1'b1;
		start = 1'b0;
		op = OP_NONE;
		arg = '0;
		wdata = '0;
		ch_zg = 1'b0;
		ch_dr = 1'b0;
		ch_dw = 1'b0;
		ch_dad = '0;
		ch_ddt = '0;
		fd = $fopen("tb/px_golden.txt", "r");
		if (fd == 0) stop_with_error("Cannot open tb/px_golden.txt");
		apply_reset();
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 9 || line[0] == "#") continue;	// Blank or comment
			n = $sscanf(line, "%c %c %h %h %h", kind, opc, a, d, e);
			if (n != 5) stop_with_error({"Bad line in golden file: ", line});
			repeat ($urandom % 4) @(posedge __clk);	// Idle gap
			case ({kind, opc})
				"CL": begin
					run_cpu(OP_LOAD, a, d, 1'b0, rd);
					check_word("rdata", rd, e);
				end
				"CS": run_cpu(OP_STORE, a, d, 1'b0, rd);
				"CA": run_cpu(OP_LOAD, a, d, 1'b1, rd);
				"CX": run_cpu(OP_STORE, a, d, 1'b1, rd);
				"CR": apply_reset();
				"HW": chan_access(1'b1, a, d, 0, cd);
				"HR": begin
					chan_access(1'b0, a, d, 0, cd);
					check_word("ch_dt", cd, e);
				end
				"HB": begin
					fork
						chan_access(1'b1, a, d, 12, cd);	// Channel sits on the bus
						begin
							n = 0;
							do step(n, LIMIT, "ch_zw"); while (!ch_zw);
							run_cpu(OP_LOAD, a, '0, 1'b0, rd);	// Starts while held off
						end
					join
					check_word("rdata", rd, e);
				end
				default: stop_with_error({"Unknown operation in golden file: ", line});
			endcase
		end
		$fclose(fd);
		$display("Done: no errors");
		$finish;
	end

endmodule

// File: hdl/px_top.sv
`timescale 1ns/10ps

module px_top #(
	parameter int ALARM_TICKS = 16,
	parameter bit STOP_ON_NOMEM = 1'b1,
	parameter int MEM_MODULES = 2
) (
	input logic __clk,
	input logic clo,
	input logic start,
	input px_pkg::op_t op,
	input px_pkg::addr_t arg,
	input px_pkg::word_t wdata,
	output px_pkg::word_t rdata,
	output logic done,
	output logic hlt_n,
	output logic awaria,
	input logic ch_zg, ch_dr, ch_dw,	// Channel master side
	input px_pkg::addr_t ch_dad,
	input px_pkg::word_t ch_ddt,
	output logic ch_zw, ch_rok, ch_ren,
	output px_pkg::word_t ch_dt
);

	logic cpu_zg, cpu_dr, cpu_dw, cpu_zw, cpu_rok, cpu_ren;	// CPU bus side
	px_pkg::addr_t cpu_dad, m_dad;
	px_pkg::word_t cpu_ddt, cpu_dt, m_ddt, m_dt;
	logic m_dr, m_dw, m_ok, m_en;	// Shared memory bus

	px #(.ALARM_TICKS(ALARM_TICKS), .STOP_ON_NOMEM(STOP_ON_NOMEM)) u_px(
		.__clk(__clk), .clo(clo), .start(start), .op(op), .arg(arg), .wdata(wdata),
		.zw(cpu_zw), .rok(cpu_rok), .ren(cpu_ren), .dt(cpu_dt),
		.zg(cpu_zg), .dr(cpu_dr), .dw(cpu_dw), .dad(cpu_dad), .ddt(cpu_ddt),
		.rdata(rdata), .done(done), .hlt_n(hlt_n), .awaria(awaria)
	);

	bus_arbiter u_arb(
		.__clk(__clk), .clo(clo),
		.cpu_zg(cpu_zg), .cpu_dr(cpu_dr), .cpu_dw(cpu_dw), .cpu_dad(cpu_dad),
		.cpu_ddt(cpu_ddt), .cpu_zw(cpu_zw), .cpu_rok(cpu_rok), .cpu_ren(cpu_ren),
		.cpu_dt(cpu_dt),
		.ch_zg(ch_zg), .ch_dr(ch_dr), .ch_dw(ch_dw), .ch_dad(ch_dad), .ch_ddt(ch_ddt),
		.ch_zw(ch_zw), .ch_rok(ch_rok), .ch_ren(ch_ren), .ch_dt(ch_dt),
		.m_dr(m_dr), .m_dw(m_dw), .m_dad(m_dad), .m_ddt(m_ddt), .m_dt(m_dt),
		.m_ok(m_ok), .m_en(m_en)
	);

	mem_slave #(.MEM_MODULES(MEM_MODULES)) u_mem(
		.__clk(__clk), .clo(clo), .dr(m_dr), .dw(m_dw), .dad(m_dad), .ddt(m_ddt),
		.dt(m_dt), .ok(m_ok), .en(m_en)
	);

endmodule

// File: hdl/mem_slave.sv
`timescale 1ns/10ps

module mem_slave #(
	parameter int MEM_MODULES = 2	// Present 4K modules from zero up
) (
	input logic __clk,	// System clock
	input logic clo,	// General clear
	input logic dr,	// Read strobe
	input logic dw,	// Write strobe
	input px_pkg::addr_t dad,	// Address
	input px_pkg::word_t ddt,	// Write data
	output px_pkg::word_t dt,	// Read data held until next read
	output logic ok,	// Present module reply
	output logic en	// Alternate reply
);

	import px_pkg::*;

	localparam int DEPTH = MEM_MODULES << MOD_SPAN_W;	// Words fitted
	localparam int IW = $clog2(DEPTH);	// Index width

	word_t mem [0:DEPTH-1];
	logic strb_q;	// Strobe seen last clock
	logic acc;	// Leading edge of a strobe
	logic present;	// Module decode
	logic [IW-1:0] idx;	// Word index inside fitted memory

	assign acc = (dr | dw) & ~strb_q;
	assign present = int'(dad[0:MOD_W-1]) < MEM_MODULES;
	assign idx = dad[16-IW:15];
	assign en = 1'b0;	// No module here answers with EN

	always_ff @(posedge __clk or posedge clo) begin
		if (clo) begin
			strb_q <= 1'b0;
			ok <= 1'b0;
		end else begin
			strb_q <= dr | dw;
			ok <= acc & present;	// REPLY_LAT clock after the edge
		end
	end

	always_ff @(posedge __clk) begin
		if (acc & present & dw) mem[idx] <= ddt;
		if (acc & present & dr) dt <= mem[idx];
	end

	// The master keeps its strobe up until the reply comes
	a_strobe_held: assert property (@(posedge __clk) disable iff (clo)
		(acc && present) |-> ##REPLY_LAT (dr || dw));

endmodule

// File: hdl/bus_arbiter.sv
`timescale 1ns/10ps

module bus_arbiter(
	input logic __clk,	// System clock
	input logic clo,	// General clear
	input logic cpu_zg, cpu_dr, cpu_dw,	// CPU request and strobes
	input px_pkg::addr_t cpu_dad,
	input px_pkg::word_t cpu_ddt,
	output logic cpu_zw, cpu_rok, cpu_ren,	// CPU grant and replies
	output px_pkg::word_t cpu_dt,
	input logic ch_zg, ch_dr, ch_dw,	// Channel request and strobes
	input px_pkg::addr_t ch_dad,
	input px_pkg::word_t ch_ddt,
	output logic ch_zw, ch_rok, ch_ren,	// Channel grant and replies
	output px_pkg::word_t ch_dt,
	output logic m_dr, m_dw,	// Strobes to memory
	output px_pkg::addr_t m_dad,
	output px_pkg::word_t m_ddt,
	input px_pkg::word_t m_dt,	// Memory read data
	input logic m_ok, m_en	// Memory replies
);

	logic busy;	// Bus owned
	logic owner;	// 1 channel, 0 CPU, kept as last owner when idle
	logic cur_zg;	// Owner still requesting
	logic pick_ch;	// Next grant goes to channel

	assign cur_zg = owner ? ch_zg : cpu_zg;
	assign pick_ch = ch_zg & (~cpu_zg | ~owner);	// Other side first when both ask

	always_ff @(posedge __clk or posedge clo) begin
		if (clo) begin
			busy <= 1'b0;
			owner <= 1'b1;	// CPU wins the first tie
		end else if (!busy || !cur_zg) begin
			busy <= cpu_zg | ch_zg;
			if (cpu_zg | ch_zg) owner <= pick_ch;
		end
	end

	assign cpu_zw = busy & ~owner & cpu_zg;
	assign ch_zw = busy & owner & ch_zg;

	// Only the granted master reaches memory
	assign m_dr = owner ? (ch_zw & ch_dr) : (cpu_zw & cpu_dr);
	assign m_dw = owner ? (ch_zw & ch_dw) : (cpu_zw & cpu_dw);
	assign m_dad = owner ? ch_dad : cpu_dad;
	assign m_ddt = owner ? ch_ddt : cpu_ddt;

	assign cpu_rok = busy & ~owner & m_ok;
	assign cpu_ren = busy & ~owner & m_en;
	assign cpu_dt = (busy & ~owner) ? m_dt : '0;
	assign ch_rok = busy & owner & m_ok;
	assign ch_ren = busy & owner & m_en;
	assign ch_dt = (busy & owner) ? m_dt : '0;

	a_grant_excl: assert property (@(posedge __clk) disable iff (clo)
		!(cpu_zw && ch_zw));

endmodule

// File: hdl/px.sv
`timescale 1ns/10ps

module px #(
	parameter int ALARM_TICKS = 16,	// No-reply timeout
	parameter bit STOP_ON_NOMEM = 1'b1	// Halt on missing memory
) (
	input logic __clk,	// System clock
	input logic clo,	// General clear
	input logic start,	// Begin an operation, sampled in P0
	input px_pkg::op_t op,	// Operation kind
	input px_pkg::addr_t arg,	// Operand address
	input px_pkg::word_t wdata,	// Word to store
	input logic zw,	// Bus grant
	input logic rok,	// OK reply
	input logic ren,	// EN reply
	input px_pkg::word_t dt,	// Returned data
	output logic zg,	// Bus request
	output logic dr,	// Read strobe
	output logic dw,	// Write strobe
	output px_pkg::addr_t dad,	// AD bus
	output px_pkg::word_t ddt,	// DT bus out
	output px_pkg::word_t rdata,	// Last word read in WR
	output logic done,	// Operation finished
	output logic hlt_n,	// Running, low when halted
	output logic awaria	// Memory fault indicator
);

	import px_pkg::*;

	logic p0, k1, wr, ww;	// One-hot state flip-flops
	op_t op_q;	// Operation captured at start
	addr_t arg_q;	// Operand address captured at start
	word_t wdata_q;	// Store data captured at start
	addr_t ic;	// Instruction counter
	logic ldstate, strob1, strob2, got;
	logic ok$, talarm, zwzg;
	logic bus_st;	// State uses the bus
	logic awaria_set;
	logic fin;	// Operation ends at this state load

	assign bus_st = k1 | wr | ww;
	assign fin = ldstate & ~talarm & (wr | ww | (k1 & (op_q == OP_NONE)));
	assign awaria_set = strob1 & talarm & bus_st;	// Alarm only inside a bus cycle

	strobgen u_strobgen(
		.__clk(__clk),
		.clo(clo),
		.ldstate(ldstate),
		.strob1(strob1),
		.strob2(strob2),
		.got(got),
		.ok$(ok$),
		.talarm(talarm),
		.busy(bus_st)
	);

	ifctl #(
		.ALARM_TICKS(ALARM_TICKS)
	) u_ifctl(
		.__clk(__clk),
		.clo(clo),
		.zgi_j(bus_st),
		.got(got),
		.zw(zw),
		.rok(rok),
		.ren(ren),
		.zg(zg),
		.zwzg(zwzg),
		.ok$(ok$),
		.talarm(talarm)
	);

	// State registers
	always_ff @(posedge __clk or posedge clo) begin
		if (clo) begin
			{p0, k1, wr, ww} <= 4'b1000;
		end else if (p0 & start & hlt_n) begin
			{p0, k1, wr, ww} <= 4'b0100;	// Start enters fetch
		end else if (ldstate) begin
			if (talarm || !k1 || op_q == OP_NONE) {p0, k1, wr, ww} <= 4'b1000;
			else if (op_q == OP_LOAD) {p0, k1, wr, ww} <= 4'b0010;
			else {p0, k1, wr, ww} <= 4'b0001;
		end
	end

	// Operand capture at start
	always_ff @(posedge __clk) begin
		if (p0 & start) begin
			op_q <= op;
			arg_q <= arg;
			wdata_q <= wdata;
		end
		if (zwzg & wr & rok) rdata <= dt;	// Operand word from memory
	end

	// Counter steps on STROB2 of a good fetch
	always_ff @(posedge __clk or posedge clo) begin
		if (clo) ic <= '0;
		else if (strob2 & k1 & ~talarm) ic <= ic + 1'b1;
	end

	always_ff @(posedge __clk or posedge clo) begin
		if (clo) begin
			done <= 1'b0;
			awaria <= 1'b0;
			hlt_n <= 1'b1;
		end else begin
			done <= fin;	// One clock after the final state load
			if (awaria_set) awaria <= 1'b1;
			if (awaria_set & STOP_ON_NOMEM) hlt_n <= 1'b0;
			else if (p0 & start) hlt_n <= 1'b1;	// First start after a halt only releases
		end
	end

	// Bus drivers, live only while holding the bus
	assign dr = zwzg & (k1 | wr);
	assign dw = zwzg & ww;
	assign dad = zwzg ? (k1 ? ic : arg_q) : '0;
	assign ddt = dw ? wdata_q : '0;

	a_state_onehot: assert property (@(posedge __clk) disable iff (clo)
		$onehot({p0, k1, wr, ww}));
	a_rw_excl: assert property (@(posedge __clk) disable iff (clo)
		!(dr && dw));

endmodule

// File: hdl/ifctl.sv
`timescale 1ns/10ps

module ifctl #(
	parameter int ALARM_TICKS = 16	// No-reply timeout in clocks
) (
	input logic __clk,	// System clock
	input logic clo,	// General clear
	input logic zgi_j,	// State needs the bus
	input logic got,	// End of state
	input logic zw,	// Grant from the arbiter
	input logic rok,	// OK received
	input logic ren,	// EN received
	output logic zg,	// Bus request level
	output logic zwzg,	// Requested and granted
	output logic ok$,	// Reply latched
	output logic talarm	// No-memory alarm
);

	localparam int CW = $clog2(ALARM_TICKS + 1);	// Alarm counter width

	logic zg_r;	// Request flip-flop
	logic ok_r;	// Reply latch
	logic [CW-1:0] cnt;	// Clocks without a reply
	logic reply;	// Either reply pulse

	assign reply = rok | ren;
	assign zg = zg_r;
	assign zwzg = zg_r & zw;
	assign ok$ = ok_r;
	assign talarm = (cnt == CW'(ALARM_TICKS));

	// Request flip-flop, got wins over a pending set
	always_ff @(posedge __clk or posedge clo) begin
		if (clo) begin
			zg_r <= 1'b0;
		end else if (got) begin
			zg_r <= 1'b0;
		end else if (zgi_j) begin
			zg_r <= 1'b1;
		end
	end

	// Only a reply seen while holding the bus counts
	always_ff @(posedge __clk or posedge clo) begin
		if (clo) begin
			ok_r <= 1'b0;
		end else if (got) begin
			ok_r <= 1'b0;
		end else if (zwzg & reply) begin
			ok_r <= 1'b1;
		end
	end

	// Timeout counter, stops at the alarm value
	always_ff @(posedge __clk or posedge clo) begin
		if (clo) begin
			cnt <= '0;
		end else if (!zg_r) begin
			cnt <= '0;	// Cleared between requests
		end else if (zwzg & ~ok_r & ~reply & ~talarm) begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

// File: hdl/strobgen.sv
`timescale 1ns/10ps

module strobgen(
	input logic __clk,	// System clock
	input logic clo,	// General clear
	output logic ldstate,	// Next state load
	output logic strob1,	// STROB1, stretched through wait
	output logic strob2,	// STROB2
	output logic got,	// End of state, drops the bus request
	input logic ok$,	// Reply latched by interface control
	input logic talarm,	// No-reply timeout
	input logic busy	// Some state other than P0
);

	import px_pkg::*;

	sg_state_t state;	// Current phase
	sg_state_t state_nx;	// Next phase

	always_comb begin
		state_nx = state;
		case (state)
			SG_IDLE: if (busy) state_nx = SG_S1;	// New state just loaded
			SG_S1: state_nx = SG_WAIT;	// One clock of STROB1
			SG_WAIT: if (ok$ | talarm) state_nx = SG_S2;	// Bus reply or alarm ends wait
			SG_S2: state_nx = SG_GOT;
			SG_GOT: state_nx = SG_IDLE;	// Settle one clock before next S1
			default: state_nx = SG_IDLE;
		endcase
	end

	always_ff @(posedge __clk or posedge clo) begin
		if (clo) begin
			state <= SG_IDLE;
		end else begin
			state <= state_nx;
		end
	end

	assign strob1 = (state == SG_S1) | (state == SG_WAIT);	// Stretched STROB1
	assign strob2 = (state == SG_S2);
	assign got = (state == SG_GOT);	// Request flip-flop clears here
	assign ldstate = (state == SG_GOT);	// State registers load on the same edge

	// GOT never repeats back to back, so the state load is a single pulse
	a_ldstate_pulse: assert property (@(posedge __clk) disable iff (clo)
		ldstate |=> !ldstate);

endmodule

// File: hdl/px_pkg.sv
package px_pkg;

	// Bus numbering puts bit 0 at the MSB end
	typedef logic [0:15] word_t;	// Data word on DT
	typedef logic [0:15] addr_t;	// Address on AD

	// Strobe sequencer phases
	typedef enum logic [2:0] {
		SG_IDLE,	// No state pending
		SG_S1,	// STROB1 proper
		SG_WAIT,	// STROB1 stretched until reply
		SG_S2,	// STROB2
		SG_GOT	// Load next state
	} sg_state_t;

	// Operation requested at start
	typedef enum logic [1:0] {
		OP_NONE,	// Fetch only
		OP_LOAD,	// Fetch, then read operand
		OP_STORE	// Fetch, then write operand
	} op_t;

	// Memory module geometry
	localparam int MOD_W = 4;	// Module number bits, top of address
	localparam int MOD_SPAN_W = 12;	// 4K words per module

	// Reply timing of the memory
	localparam int REPLY_LAT = 1;	// Clocks from strobe edge to OK

endpackage
